//--- rms_fixed_pkg.sv
// ******************************
// Fixed-point formats of the
// data path and the beat struct
// ******************************

package rms_fixed_pkg;

    // Values carried per beat
    localparam int lanes = 4;

    // Activations in, signed Q5.2
    localparam int in_width = 8;
    localparam int in_frac = 2;

    // Normalized activations out, signed Q3.4
    localparam int out_width = 8;
    localparam int out_frac = 4;

    // One square keeps 4 fractional bits
    localparam int sq_width = 16;

    // Clamped mean square, unsigned Q12.4
    localparam int ms_width = 16;
    localparam int ms_frac = 4;

    // Inverse root, unsigned Q4.12
    localparam int inv_width = 16;
    localparam int inv_frac = 12;

    // One beat of the stream, lane 0 in the low byte
    // Input and output widths are equal so one type serves both
    typedef struct packed {
        logic [lanes-1:0][in_width-1:0] lane;
    } beat_t;

endpackage

//--- rms_csr_pkg.sv
// ******************************
// Register map, AXI4-Lite
// request and response structs,
// config and status structs
// ******************************

package rms_csr_pkg;

    localparam int axil_addr_width = 4;
    localparam int axil_data_width = 32;

    // Register offsets
    localparam logic [axil_addr_width-1:0] reg_ctrl_addr = 4'h0;
    localparam logic [axil_addr_width-1:0] reg_status_addr = 4'h4;

    // Field positions inside CTRL and STATUS
    localparam int ctrl_en_bit = 0;
    localparam int ctrl_len_lsb = 1;
    localparam int stat_clamp_bit = 16;

    localparam logic [1:0] resp_okay = 2'b00;

    // Fields driven by the AXI4-Lite master
    typedef struct packed {
        logic [axil_addr_width-1:0] awaddr;
        logic                       awvalid;
        logic [axil_data_width-1:0] wdata;
        logic [3:0]                 wstrb;
        logic                       wvalid;
        logic                       bready;
        logic [axil_addr_width-1:0] araddr;
        logic                       arvalid;
        logic                       rready;
    } axil_req_t;

    // Fields driven by the slave
    typedef struct packed {
        logic                       awready;
        logic                       wready;
        logic                       bvalid;
        logic [1:0]                 bresp;
        logic                       arready;
        logic                       rvalid;
        logic [axil_data_width-1:0] rdata;
        logic [1:0]                 rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic       enable;
        logic [2:0] len_log2;
    } norm_cfg_t;

    // Disabled, 4-beat frames
    localparam norm_cfg_t cfg_reset = '{enable: 1'b0, len_log2: 3'd2};

    // clamped is only meaningful with frame_done
    typedef struct packed {
        logic frame_done;
        logic clamped;
    } norm_stat_t;

endpackage

//--- rms_csr.sv
// ******************************
// AXI4-Lite slave with the CTRL
// register, frame counter and
// sticky clamp flag
// ******************************

module rms_csr #(
    parameter int MAX_LEN_LOG2 = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rms_csr_pkg::axil_req_t  req,
    output rms_csr_pkg::axil_rsp_t  rsp,
    output rms_csr_pkg::norm_cfg_t  cfg,
    input  rms_csr_pkg::norm_stat_t stat
);
    import rms_csr_pkg::*;

    logic                       aw_ready;
    logic                       b_valid;
    logic                       ar_ready;
    logic                       r_valid;
    logic [axil_data_width-1:0] r_data;
    logic [axil_data_width-1:0] rd_word;
    logic [15:0]                frames_done;
    logic                       clamp_seen;
    logic                       wr_fire;
    logic                       clamp_clear;
    logic [2:0]                 wr_len;

    assign wr_fire = aw_ready && req.awvalid && req.wvalid;
    assign clamp_clear = wr_fire && req.awaddr == reg_status_addr && req.wstrb[2]
                         && req.wdata[stat_clamp_bit];

    // Longer frames than the FIFO can hold are cut back
    assign wr_len = (req.wdata[ctrl_len_lsb +: 3] > 3'(MAX_LEN_LOG2)) ?
                    3'(MAX_LEN_LOG2) : req.wdata[ctrl_len_lsb +: 3];

    // Write channel and CTRL
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_ready <= 1'b0;
            b_valid <= 1'b0;
            cfg <= cfg_reset;
        end else begin
            aw_ready <= req.awvalid && req.wvalid && !aw_ready && !b_valid;
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (req.bready) begin
                b_valid <= 1'b0;
            end
            if (wr_fire && req.awaddr == reg_ctrl_addr && req.wstrb[0]) begin
                cfg.enable <= req.wdata[ctrl_en_bit];
                cfg.len_log2 <= wr_len;
            end
        end
    end

    // Status, a new clamp wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frames_done <= '0;
            clamp_seen <= 1'b0;
        end else begin
            if (stat.frame_done) begin
                frames_done <= frames_done + 16'd1;
            end
            if (stat.frame_done && stat.clamped) begin
                clamp_seen <= 1'b1;
            end else if (clamp_clear) begin
                clamp_seen <= 1'b0;
            end
        end
    end

    always_comb begin
        case (req.araddr)
            reg_ctrl_addr:   rd_word = {28'd0, cfg.len_log2, cfg.enable};
            reg_status_addr: rd_word = {15'd0, clamp_seen, frames_done};
            default:         rd_word = '0;
        endcase
    end

    // Read channel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ar_ready <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            ar_ready <= req.arvalid && !ar_ready && !r_valid;
            if (ar_ready && req.arvalid) begin
                r_valid <= 1'b1;
            end else if (req.rready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_ready && req.arvalid) begin
            r_data <= rd_word;
        end
    end

    always_comb begin
        rsp = '0;
        rsp.awready = aw_ready;
        rsp.wready = aw_ready;
        rsp.bvalid = b_valid;
        rsp.bresp = resp_okay;
        rsp.arready = ar_ready;
        rsp.rvalid = r_valid;
        rsp.rdata = r_data;
        rsp.rresp = resp_okay;
    end

    // Every B response answers a write taken one cycle earlier
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp.bvalid) |-> $past(rsp.awready && req.awvalid && req.wvalid))
        else $error("bvalid raised without an accepted write");

endmodule

//--- rms_isqrt.sv
// ******************************
// Inverse square root of the
// mean square, bitwise integer
// root then restoring division
// ******************************

module rms_isqrt (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [rms_fixed_pkg::ms_width-1:0]  ms,
    input  logic                                ms_valid,
    output logic                                ms_ready,
    output logic [rms_fixed_pkg::inv_width-1:0] inv,
    output logic                                inv_valid,
    input  logic                                inv_ready
);
    import rms_fixed_pkg::*;

    localparam int root_width = ms_width / 2;
    localparam int root_frac = ms_frac / 2;

    // 1.0 in Q12 over a root in Q2
    localparam logic [inv_width-1:0] dividend = inv_width'(1) << (inv_frac + root_frac);

    typedef enum logic [2:0] {
        st_idle,
        st_sqrt,
        st_div,
        st_out,
        st_hold
    } state_t;

    state_t                state;
    logic [3:0]            step;
    logic [ms_width-1:0]   radicand;
    logic [root_width-1:0] root;
    logic [root_width-1:0] trial;
    logic [ms_width-1:0]   trial_sq;
    logic [root_width-1:0] rem;
    logic [inv_width-1:0]  quo;
    logic [root_width:0]   part;
    logic [root_width:0]   diff;
    logic                  fits;

    assign ms_ready = (state == st_idle);

    // Try one more root bit per cycle, MSB first
    assign trial = root | (root_width'(1) << step[2:0]);
    assign trial_sq = trial * trial;

    // Shift the next dividend bit into the remainder
    assign part = {rem, quo[inv_width-1]};
    assign diff = part - {1'b0, root};
    assign fits = part >= {1'b0, root};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            inv_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: if (ms_valid) state <= st_sqrt;
                st_sqrt: if (step == 4'd0) state <= st_div;
                st_div:  if (step == 4'd0) state <= st_out;
                st_out: begin
                    state <= st_hold;
                    inv_valid <= 1'b1;
                end
                st_hold: begin
                    if (inv_ready) begin
                        state <= st_idle;
                        inv_valid <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // A zero root sets every quotient bit, giving 0xFFFF
    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                radicand <= ms;
                root <= '0;
                step <= 4'(root_width - 1);
            end
            st_sqrt: begin
                if (trial_sq <= radicand) begin
                    root <= trial;
                end
                if (step == 4'd0) begin
                    rem <= '0;
                    quo <= dividend;
                    step <= 4'(inv_width - 1);
                end else begin
                    step <= step - 4'd1;
                end
            end
            st_div: begin
                rem <= fits ? diff[root_width-1:0] : part[root_width-1:0];
                quo <= {quo[inv_width-2:0], fits};
                step <= step - 4'd1;
            end
            st_out: inv <= quo;
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        inv_valid && !inv_ready |=> inv_valid && $stable(inv))
        else $error("inverse root changed while stalled");

endmodule

//--- rms_norm_core.sv
// ******************************
// RMS normalization data path
//   beat FIFO, square-accumulate
//   mean shift and clamp
//   replay multiply and cast
// ******************************

module rms_norm_core #(
    parameter int MAX_LEN_LOG2 = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rms_csr_pkg::norm_cfg_t  cfg,
    output rms_csr_pkg::norm_stat_t stat,
    input  rms_fixed_pkg::beat_t    in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    output rms_fixed_pkg::beat_t    out_beat,
    output logic                    out_valid,
    input  logic                    out_ready
);
    import rms_fixed_pkg::*;

    // Room for one frame accumulating and one replaying
    localparam int fifo_depth = 2 * (2 ** MAX_LEN_LOG2);
    localparam int ptr_width = MAX_LEN_LOG2 + 1;
    localparam int cnt_width = MAX_LEN_LOG2 + 1;
    localparam int acc_width = 18 + MAX_LEN_LOG2;
    localparam int norm_shift = in_frac + inv_frac - out_frac;
    localparam int out_max = 2 ** (out_width - 1) - 1;
    localparam int out_min = -(2 ** (out_width - 1));

    typedef struct packed {
        logic [2:0]           len_log2;
        logic                 clamped;
        logic [inv_width-1:0] inv;
    } frame_t;

    function automatic logic [sq_width+1:0] sum_squares(input beat_t b);
        logic [sq_width+1:0] sum;
        logic [sq_width-1:0] sq;
        sum = '0;
        for (int i = 0; i < lanes; i++) begin
            sq = $signed(b.lane[i]) * $signed(b.lane[i]);
            sum = sum + sq;
        end
        return sum;
    endfunction

    // Floor of lane times inverse root, saturated to Q3.4
    function automatic logic [out_width-1:0] norm_lane(input logic [in_width-1:0] x,
                                                        input logic [inv_width-1:0] g);
        logic signed [in_width+inv_width:0] prod;
        logic signed [in_width+inv_width:0] scaled;
        prod = $signed(x) * $signed({1'b0, g});
        scaled = prod >>> norm_shift;
        if (scaled > out_max) begin
            return out_width'(out_max);
        end else if (scaled < out_min) begin
            return out_width'(out_min);
        end
        return scaled[out_width-1:0];
    endfunction

    beat_t                fifo_mem [fifo_depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   fifo_count;
    logic                 in_fire;
    logic                 rd_fire;
    logic                 last_in;
    logic                 last_out;
    logic [cnt_width-1:0] in_cnt;
    logic [cnt_width-1:0] rd_cnt;
    logic [2:0]           cur_len;
    logic [2:0]           in_len;
    logic [acc_width-1:0] acc;
    logic [acc_width-1:0] acc_next;
    logic [acc_width-1:0] mean;
    logic [ms_width-1:0]  ms_q;
    logic                 ms_pend;
    logic                 ms_ready;
    logic [2:0]           ms_len;
    logic                 ms_clamped;
    logic [2:0]           isq_len;
    logic                 isq_clamped;
    logic [inv_width-1:0] inv;
    logic                 inv_valid;
    logic                 inv_ready;
    frame_t               frame_q [2];
    logic                 wq_ptr;
    logic                 rq_ptr;
    logic [1:0]           q_count;
    frame_t               head;
    logic                 out_last;
    logic                 out_clamped;

    assign in_ready = cfg.enable && fifo_count != fifo_depth && !ms_pend;
    assign in_fire = in_valid && in_ready;

    // Length is taken from CTRL on the first beat only
    assign in_len = (in_cnt == '0) ? cfg.len_log2 : cur_len;
    assign last_in = in_cnt == cnt_width'((1 << in_len) - 1);
    assign acc_next = acc + acc_width'(sum_squares(in_beat));

    // Four lanes per beat, so divide by 2^(len+2)
    assign mean = acc_next >> ({1'b0, in_len} + 4'd2);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_cnt <= '0;
            acc <= '0;
            ms_pend <= 1'b0;
            wr_ptr <= '0;
        end else begin
            if (in_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
                in_cnt <= last_in ? '0 : in_cnt + 1'b1;
                acc <= last_in ? '0 : acc_next;
                ms_pend <= last_in;
            end else if (ms_pend && ms_ready) begin
                ms_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            fifo_mem[wr_ptr] <= in_beat;
            if (in_cnt == '0) cur_len <= cfg.len_log2;
            if (last_in) begin
                ms_q <= (|mean[acc_width-1:ms_width]) ? '1 : mean[ms_width-1:0];
                ms_clamped <= |mean[acc_width-1:ms_width];
                ms_len <= in_len;
            end
        end
        // The isqrt may take the next frame's sum before this result returns
        if (ms_pend && ms_ready) begin
            isq_len <= ms_len;
            isq_clamped <= ms_clamped;
        end
        if (inv_valid && inv_ready) begin
            frame_q[wq_ptr] <= '{len_log2: isq_len, clamped: isq_clamped, inv: inv};
        end
    end

    rms_isqrt i_isqrt (
        .clk       (clk),
        .rst_n     (rst_n),
        .ms        (ms_q),
        .ms_valid  (ms_pend),
        .ms_ready  (ms_ready),
        .inv       (inv),
        .inv_valid (inv_valid),
        .inv_ready (inv_ready)
    );

    assign inv_ready = q_count != 2'd2;

    // Replay needs both a buffered beat and its frame's inverse root
    assign head = frame_q[rq_ptr];
    assign rd_fire = fifo_count != '0 && q_count != 2'd0 && (!out_valid || out_ready);
    assign last_out = rd_cnt == cnt_width'((1 << head.len_log2) - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            rd_cnt <= '0;
            fifo_count <= '0;
            wq_ptr <= 1'b0;
            rq_ptr <= 1'b0;
            q_count <= '0;
            out_valid <= 1'b0;
            stat <= '0;
        end else begin
            fifo_count <= fifo_count + (ptr_width + 1)'(in_fire) - (ptr_width + 1)'(rd_fire);
            q_count <= q_count + 2'(inv_valid && inv_ready) - 2'(rd_fire && last_out);
            if (inv_valid && inv_ready) wq_ptr <= ~wq_ptr;
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
                rd_cnt <= last_out ? '0 : rd_cnt + 1'b1;
                if (last_out) rq_ptr <= ~rq_ptr;
            end
            if (rd_fire) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            stat.frame_done <= out_valid && out_ready && out_last;
            stat.clamped <= out_clamped;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            for (int i = 0; i < lanes; i++) begin
                out_beat.lane[i] <= norm_lane(fifo_mem[rd_ptr].lane[i], head.inv);
            end
            out_last <= last_out;
            out_clamped <= head.clamped;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) fifo_count <= fifo_depth)
        else $error("beat FIFO overflow");

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed under back-pressure");

endmodule

//--- rms_norm_top.sv
// ******************************
// Top level, register block
// beside the normalization core
// ******************************

module rms_norm_top #(
    parameter int MAX_LEN_LOG2 = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rms_csr_pkg::axil_req_t req,
    output rms_csr_pkg::axil_rsp_t rsp,
    input  rms_fixed_pkg::beat_t   in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output rms_fixed_pkg::beat_t   out_beat,
    output logic                   out_valid,
    input  logic                   out_ready
);
    import rms_csr_pkg::*;

    norm_cfg_t  cfg;
    norm_stat_t stat;

    rms_csr #(
        .MAX_LEN_LOG2 (MAX_LEN_LOG2)
    ) i_csr (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp),
        .cfg   (cfg),
        .stat  (stat)
    );

    rms_norm_core #(
        .MAX_LEN_LOG2 (MAX_LEN_LOG2)
    ) i_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .stat      (stat),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

//--- tb_rms_norm.sv
// ******************************
// Testbench for rms_norm_top
//   clock, reset, AXI4-Lite tasks
//   file-driven stimulus and
//   scoreboard, LFSR back-pressure
//   and watchdog
// ******************************

module tb_rms_norm;
    timeunit 1ns;
    timeprecision 1ps;

    import rms_fixed_pkg::*;
    import rms_csr_pkg::*;

    localparam string stim_path = "tb_rms_norm_input.txt";
    localparam logic [15:0] lfsr_seed = 16'd17696;

    logic      clk;
    logic      rst_n;
    axil_req_t req;
    axil_rsp_t rsp;
    beat_t     in_beat;
    logic      in_valid;
    logic      in_ready;
    beat_t     out_beat;
    logic      out_valid;
    logic      out_ready;

    // Beats waiting to be driven and beats the DUT still owes
    beat_t in_q[$];
    beat_t exp_q[$];

    int    line_count = 0;
    int    tests = 0;
    int    checks = 0;
    int    errors = 0;
    int    test_beats = 0;
    int    test_errors = 0;
    string test_name = "";
    bit    core_enabled = 1'b0;

    rms_norm_top #(
        .MAX_LEN_LOG2 (4)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .rsp       (rsp),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic beat_t make_beat(input int v0, input int v1, input int v2, input int v3);
        beat_t b;
        b.lane[0] = 8'(v0);
        b.lane[1] = 8'(v1);
        b.lane[2] = 8'(v2);
        b.lane[3] = 8'(v3);
        return b;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] expected,
                         input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            test_errors++;
            $display("Mismatch at time %0t: %s, got %h, expected %h",
                     $time, what, got, expected);
        end
    endtask

    task automatic log_failure(input string what);
        errors++;
        test_errors++;
        $display("Error at time %0t: %s", $time, what);
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        req.awaddr <= addr;
        req.awvalid <= 1'b1;
        req.wdata <= data;
        req.wstrb <= 4'hf;
        req.wvalid <= 1'b1;
        req.bready <= 1'b1;
        do @(posedge clk); while (!rsp.awready);
        req.awvalid <= 1'b0;
        req.wvalid <= 1'b0;
        // CTRL takes the new value on this very edge
        if (addr == reg_ctrl_addr) begin
            core_enabled <= data[0];
        end
        do @(posedge clk); while (!rsp.bvalid);
        // Every access answers OKAY
        check(rsp.bresp, 2'b00, $sformatf("write response of register 0x%h", addr));
        req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        req.araddr <= addr;
        req.arvalid <= 1'b1;
        req.rready <= 1'b1;
        do @(posedge clk); while (!rsp.arready);
        req.arvalid <= 1'b0;
        do @(posedge clk); while (!rsp.rvalid);
        data = rsp.rdata;
        check(rsp.rresp, 2'b00, $sformatf("read response of register 0x%h", addr));
        req.rready <= 1'b0;
    endtask

    // Wait until every queued beat went in and every expected beat came out
    task automatic close_test();
        if (test_name != "") begin
            while (in_q.size() != 0 || exp_q.size() != 0) begin
                @(posedge clk);
            end
            $display("Test %s done: %0d beats checked, %0d errors",
                     test_name, test_beats, test_errors);
        end
    endtask

    task automatic end_run();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Input stream, a beat stays on the bus until it is taken
    initial begin : input_driver
        in_valid = 1'b0;
        in_beat = '0;
        forever begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                in_q.delete(0);
            end
            if (in_q.size() != 0) begin
                in_valid <= 1'b1;
                in_beat <= in_q[0];
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    // Scoreboard and random out_ready
    initial begin : output_monitor
        logic [15:0] lfsr;
        beat_t       expected;
        lfsr = lfsr_seed;
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    log_failure("output beat appeared with no expected beat pending");
                end else begin
                    expected = exp_q.pop_front();
                    test_beats++;
                    check(out_beat, expected,
                          $sformatf("output beat %0d of test %s", test_beats, test_name));
                end
            end
            if (rst_n && in_valid && in_ready && !core_enabled) begin
                log_failure("input beat accepted while the core was disabled");
            end
            lfsr = lfsr_step(lfsr);
            out_ready <= lfsr[0];
        end
    end

    initial begin : watchdog
        wait (line_count > 0);
        repeat (line_count * 64 + 1000) @(posedge clk);
        log_failure("the run timed out before the stimulus file was finished");
        end_run();
    end

    initial begin : main
        int          fd;
        int          rc;
        string       line;
        string       cmd;
        string       name;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] got;
        int          v0;
        int          v1;
        int          v2;
        int          v3;
        req = '0;
        rst_n = 1'b0;
        fd = $fopen(stim_path, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                line_count++;
            end
            $fclose(fd);
            fd = $fopen(stim_path, "r");
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        if (fd == 0) begin
            log_failure("could not open the stimulus file");
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "#") begin
                    rc = $fgets(line, fd);
                end else if (cmd == "T") begin
                    rc = $fscanf(fd, "%s", name);
                    close_test();
                    test_name = name;
                    test_beats = 0;
                    test_errors = 0;
                    tests++;
                end else if (cmd == "W") begin
                    rc = $fscanf(fd, "%h %h", addr, data);
                    axil_write(addr[3:0], data);
                end else if (cmd == "R") begin
                    rc = $fscanf(fd, "%h %h", addr, data);
                    while (exp_q.size() != 0) begin
                        @(posedge clk);
                    end
                    // frame_done pulse, then the counter update
                    repeat (2) @(posedge clk);
                    axil_read(addr[3:0], got);
                    check(got, data, $sformatf("read of register 0x%h", addr[3:0]));
                end else if (cmd == "I") begin
                    rc = $fscanf(fd, "%d %d %d %d", v0, v1, v2, v3);
                    in_q.push_back(make_beat(v0, v1, v2, v3));
                end else if (cmd == "E") begin
                    rc = $fscanf(fd, "%d %d %d %d", v0, v1, v2, v3);
                    exp_q.push_back(make_beat(v0, v1, v2, v3));
                end else begin
                    log_failure($sformatf("unknown command %s in the stimulus file", cmd));
                    rc = $fgets(line, fd);
                end
            end
            $fclose(fd);
            close_test();
        end
        end_run();
    end

endmodule

//--- flist.f
rms_fixed_pkg.sv
rms_csr_pkg.sv
rms_csr.sv
rms_isqrt.sv
rms_norm_core.sv
rms_norm_top.sv
tb_rms_norm.sv

//--- Bender.yml
package:
  name: rms_norm

sources:
  - rms_fixed_pkg.sv
  - rms_csr_pkg.sv
  - rms_csr.sv
  - rms_isqrt.sv
  - rms_norm_core.sv
  - rms_norm_top.sv
  - target: test
    files:
      - tb_rms_norm.sv

//--- tb_rms_norm_input.txt
# T name, W addr data, R addr expected, with addr and data in hex
# I and E give lanes 0 to 3 of an input or expected output beat in signed decimal
T registers
R 0 4
W 0 f
R 0 9
W 0 5
R 0 5
R c 0
T frame_len4
I 8 -8 16 -16
I 4 -4 12 -12
I 0 20 -20 2
I 40 -40 6 -6
E 7 -8 15 -16
E 3 -4 11 -12
E 0 18 -19 1
E 37 -38 5 -6
T len_change
W 0 1
I 10 -6 1 -3
E 26 -16 2 -8
W 0 7
I 4 -4 4 -4
I 8 0 0 0
I 0 -8 0 0
I -4 4 -4 4
I 0 0 8 0
I 0 0 0 -8
I 4 4 4 4
I -4 -4 -4 -4
E 16 -16 16 -16
E 32 0 0 0
E 0 -32 0 0
E -16 16 -16 16
E 0 0 32 0
E 0 0 0 -32
E 16 16 16 16
E -16 -16 -16 -16
T full_scale
W 0 5
I -128 -128 -128 -128
I -128 -128 -128 -128
I -128 -128 -128 -128
I -128 -128 -128 -128
E -16 -16 -16 -16
E -16 -16 -16 -16
E -16 -16 -16 -16
E -16 -16 -16 -16
R 4 4
W 4 10000
R 4 4
T zero_count
W 0 1
I 0 0 0 0
E 0 0 0 0
R 4 5
T disable
W 0 4
I 3 0 0 -2
I 1 0 0 0
I 0 -1 0 0
I 0 0 0 0
R 4 5
R 4 5
W 0 5
E 127 0 0 -128
E 63 0 0 0
E 0 -64 0 0
E 0 0 0 0
R 4 6
